// File: verilog.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_array_if.sv
hdl/dcache_sram.sv
hdl/dcache_arrays.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_mem_model.sv
testbench/tb_dcache.sv

// File: testbench/tb_dcache.sv
// ####################################################################
// data cache testbench
// clock, reset, directed tests, timeout and summary
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
  import dcache_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 10;
  localparam int SEED          = 58998;
  localparam int MAX_ACCESSES  = 200;
  localparam int ACCESS_CYCLES = 20;  // dirty miss with slow memory
  localparam int TIMEOUT       = MAX_ACCESSES * ACCESS_CYCLES;

  logic  clk;
  logic  rst;
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;
  logic  r_valid;
  logic  r_ready;
  word_t r_data;
  logic  aw_valid;
  logic  w_valid;
  logic  aw_ready;
  addr_t aw_addr;
  word_t w_data;
  strb_t w_strb;
  logic  b_valid;
  logic  b_ready;
  logic  mem_ar_valid;
  logic  mem_ar_ready;
  addr_t mem_ar_addr;
  logic  mem_r_valid;
  logic  mem_r_ready;
  word_t mem_r_data;
  logic  mem_aw_valid;
  logic  mem_aw_ready;
  addr_t mem_aw_addr;
  logic  mem_w_valid;
  logic  mem_w_ready;
  word_t mem_w_data;
  logic  mem_b_valid;
  logic  mem_b_ready;

  integer seed;
  int     cycles = 0;
  int     errors = 0;
  int     tests_run = 0;
  word_t  ref_mem [addr_t];  // CPU view after each write

  dcache_top dut0 (
    .clk (clk), .rst (rst),
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr),
    .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data),
    .aw_valid_i (aw_valid), .w_valid_i (w_valid), .aw_ready_o (aw_ready),
    .aw_addr_i (aw_addr), .w_data_i (w_data), .w_strb_i (w_strb),
    .b_valid_o (b_valid), .b_ready_i (b_ready),
    .mem_ar_valid_o (mem_ar_valid), .mem_ar_ready_i (mem_ar_ready),
    .mem_ar_addr_o (mem_ar_addr),
    .mem_r_valid_i (mem_r_valid), .mem_r_ready_o (mem_r_ready),
    .mem_r_data_i (mem_r_data),
    .mem_aw_valid_o (mem_aw_valid), .mem_aw_ready_i (mem_aw_ready),
    .mem_aw_addr_o (mem_aw_addr),
    .mem_w_valid_o (mem_w_valid), .mem_w_ready_i (mem_w_ready),
    .mem_w_data_o (mem_w_data),
    .mem_b_valid_i (mem_b_valid), .mem_b_ready_o (mem_b_ready)
  );

  dcache_mem_model #(.SEED(SEED)) mem0 (
    .clk (clk), .rst (rst),
    .ar_valid_i (mem_ar_valid), .ar_ready_o (mem_ar_ready), .ar_addr_i (mem_ar_addr),
    .r_valid_o (mem_r_valid), .r_ready_i (mem_r_ready), .r_data_o (mem_r_data),
    .aw_valid_i (mem_aw_valid), .aw_ready_o (mem_aw_ready), .aw_addr_i (mem_aw_addr),
    .w_valid_i (mem_w_valid), .w_ready_o (mem_w_ready), .w_data_i (mem_w_data),
    .b_valid_o (mem_b_valid), .b_ready_i (mem_b_ready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
      $display("Done: errors found");
      $finish;
    end
  end

  // any byte of the word, the cache ignores the offset
  function automatic addr_t make_addr(tag_t t, index_t i);
    addr_t r;
    r = $random(seed);
    return {t, i, r[2:0]};
  endfunction

  function automatic addr_t line_addr(addr_t a);
    return {a[31:3], 3'b000};
  endfunction

  function automatic tag_t next_tag();
    return tag_t'($random(seed));
  endfunction

  function automatic word_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic strb_t byte_strobe();
    return strb_t'($random(seed)) | 8'h01;  // at least one lane
  endfunction

  function automatic int stall_cycles();
    return 1 + ($unsigned($random(seed)) % 6);
  endfunction

  // byte lanes under the strobe take the new data
  function automatic word_t apply_strobe(word_t old_w, word_t new_w, strb_t strb);
    word_t mask;
    for (int b = 0; b < 8; b++) mask[b*8 +: 8] = {8{strb[b]}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic word_t expected_word(addr_t a);
    addr_t la;
    la = line_addr(a);
    if (ref_mem.exists(la)) return ref_mem[la];
    return mem0.peek(la);
  endfunction

  task automatic report_err(input string msg);
    $display("ERR %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
  endtask

  // lat counts rising edges from the accepting one up to r_valid
  task automatic read_and_check(input addr_t a, input int stall, output int lat);
    word_t exp_w;
    word_t got;
    exp_w    = expected_word(a);
    ar_addr  = a;
    ar_valid = 1'b1;
    while (!ar_ready) @(negedge clk);
    @(posedge clk);
    lat = 1;
    @(negedge clk);
    ar_valid = 1'b0;
    while (!r_valid) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    got = r_data;
    if (got !== exp_w) report_err($sformatf("read %h got %h, expected %h", a, got, exp_w));
    repeat (stall) begin
      if (ar_ready || aw_ready) report_err("CPU ready high while read response stalled");
      @(negedge clk);
      if (!r_valid || r_data !== got) report_err($sformatf("read response at %h moved", a));
    end
    r_ready = 1'b1;
    @(negedge clk);
    r_ready = 1'b0;
    if (r_valid || !ar_ready) report_err("read response handshake did not complete");
  endtask

  task automatic write_and_check(input addr_t a, input word_t data, input strb_t strb,
                                 input int stall);
    ref_mem[line_addr(a)] = apply_strobe(expected_word(a), data, strb);
    aw_addr  = a;
    w_data   = data;
    w_strb   = strb;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    while (!aw_ready) @(negedge clk);
    @(posedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    while (!b_valid) @(negedge clk);
    repeat (stall) begin
      if (ar_ready || aw_ready) report_err("CPU ready high while write response stalled");
      @(negedge clk);
      if (!b_valid) report_err($sformatf("write response at %h dropped", a));
    end
    b_ready = 1'b1;
    @(negedge clk);
    b_ready = 1'b0;
    if (b_valid || !aw_ready) report_err("write response handshake did not complete");
  endtask

  task automatic reset_state_test();
    int    err0;
    int    rd0;
    int    lat;
    err0 = errors;
    if ({r_valid, b_valid, mem_ar_valid, mem_aw_valid, mem_w_valid} !== 5'b0)
      report_err("a valid output is not low after reset");
    if ({mem_r_ready, mem_b_ready} !== 2'b0) report_err("memory ready high after reset");
    if ({ar_ready, aw_ready} !== 2'b11) report_err("CPU ready low after reset");
    rd0 = mem0.rd_cnt;
    read_and_check(make_addr(next_tag(), 6'd0), 0, lat);
    if (mem0.rd_cnt != rd0 + 1) report_err("first read after reset did not miss");
    finish_test("reset state", err0);
  endtask

  task automatic read_hit_test();
    int    err0;
    int    rd0;
    int    lat;
    addr_t a;
    err0 = errors;
    a    = make_addr(next_tag(), 6'd1);
    rd0  = mem0.rd_cnt;
    read_and_check(a, 0, lat);
    if (mem0.rd_cnt != rd0 + 1) report_err("read miss made no memory read");
    read_and_check(a, 0, lat);
    if (mem0.rd_cnt != rd0 + 1) report_err("read hit went to memory");
    if (lat != 2) report_err($sformatf("hit latency %0d edges, expected 2", lat));
    finish_test("read hit", err0);
  endtask

  task automatic strobe_write_test();
    int    err0;
    int    wb0;
    int    lat;
    addr_t a;
    word_t old_w;
    err0 = errors;
    a    = make_addr(next_tag(), 6'd2);
    read_and_check(a, 0, lat);
    old_w = mem0.peek(line_addr(a));
    wb0   = mem0.wb_cnt;
    write_and_check(a, random_word(), byte_strobe(), 0);
    read_and_check(a, 0, lat);
    if (mem0.wb_cnt != wb0) report_err("write hit reached memory");
    if (mem0.peek(line_addr(a)) !== old_w) report_err($sformatf("memory word at %h changed", a));
    finish_test("strobed write", err0);
  endtask

  task automatic write_allocate_test();
    int    err0;
    int    rd0;
    int    lat;
    addr_t a;
    err0 = errors;
    a    = make_addr(next_tag(), 6'd3);
    rd0  = mem0.rd_cnt;
    write_and_check(a, random_word(), byte_strobe(), 0);
    if (mem0.rd_cnt != rd0 + 1) report_err("write miss did not fetch the line");
    read_and_check(a, 0, lat);
    if (mem0.rd_cnt != rd0 + 1) report_err("read after allocate went to memory");
    finish_test("write allocate", err0);
  endtask

  task automatic dirty_eviction_test();
    int    err0;
    int    wb0;
    int    lat;
    tag_t  base;
    addr_t addrs [5];
    err0 = errors;
    base = next_tag();
    wb0  = mem0.wb_cnt;
    for (int i = 0; i < 5; i++) begin
      addrs[i] = make_addr(base + tag_t'(i), 6'd5);
      write_and_check(addrs[i], random_word(), byte_strobe(), 0);
    end
    for (int i = 0; i < 5; i++) read_and_check(addrs[i], 0, lat);
    if (mem0.wb_cnt - wb0 < 3) report_err($sformatf("only %0d writebacks", mem0.wb_cnt - wb0));
    for (int i = 0; i < 5; i++) begin
      if (mem0.has_wb(line_addr(addrs[i])) &&
          mem0.last_wb(line_addr(addrs[i])) !== expected_word(addrs[i]))
        report_err($sformatf("writeback to %h carried a stale word", addrs[i]));
    end
    finish_test("dirty eviction", err0);
  endtask

  task automatic back_pressure_test();
    int    err0;
    int    lat;
    tag_t  t;
    err0 = errors;
    t    = next_tag();
    write_and_check(make_addr(t, 6'd7), random_word(), byte_strobe(), stall_cycles());
    read_and_check(make_addr(t, 6'd7), stall_cycles(), lat);
    read_and_check(make_addr(t + 1'b1, 6'd7), stall_cycles(), lat);
    finish_test("back-pressure", err0);
  endtask

  initial begin
    seed     = SEED;
    rst      = 1'b1;
    ar_valid = 1'b0;
    ar_addr  = '0;
    r_ready  = 1'b0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    aw_addr  = '0;
    w_data   = '0;
    w_strb   = '0;
    b_ready  = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    reset_state_test();
    read_hit_test();
    strobe_write_test();
    write_allocate_test();
    dirty_eviction_test();
    back_pressure_test();
    if (mem0.bad_cnt != 0) report_err("memory saw addresses with offset bits set");
    $display("summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/dcache_mem_model.sv
// ####################################################################
// behavioural main memory for the data cache testbench
// sparse image, random 0..3 cycle answers, writeback log
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model #(
  parameter int SEED = 1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  dcache_pkg::addr_t ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output dcache_pkg::word_t r_data_o,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  dcache_pkg::addr_t aw_addr_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  dcache_pkg::word_t w_data_i,
  output logic              b_valid_o,
  input  logic              b_ready_i
);
  import dcache_pkg::*;

  word_t  image  [addr_t];
  word_t  wr_log [addr_t];  // last writeback per address
  integer seed;
  int     rd_cnt  = 0;
  int     wb_cnt  = 0;
  int     bad_cnt = 0;      // addresses with offset bits set
  addr_t  addr;

  function automatic word_t peek(addr_t a);
    if (image.exists(a)) return image[a];
    return {a ^ 32'h9e37_79b9, ~a};  // untouched words follow the address
  endfunction

  function automatic logic has_wb(addr_t a);
    return wr_log.exists(a) != 0;
  endfunction

  function automatic word_t last_wb(addr_t a);
    return wr_log[a];
  endfunction

  task automatic random_wait();
    repeat ($unsigned($random(seed)) % 4) @(negedge clk);
  endtask

  // one request at a time, every output moves on the falling edge
  initial begin
    seed       = SEED;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst && ar_valid_i) begin
        addr = ar_addr_i;
        if (addr[2:0] != 3'b000) bad_cnt++;
        random_wait();
        ar_ready_o = 1'b1;
        @(negedge clk);             // taken on the edge in between
        ar_ready_o = 1'b0;
        rd_cnt++;
        random_wait();
        r_data_o  = peek(addr);
        r_valid_o = 1'b1;
        while (!r_ready_i) @(negedge clk);
        @(negedge clk);
        r_valid_o = 1'b0;
      end else if (!rst && aw_valid_i) begin
        addr = aw_addr_i;
        if (addr[2:0] != 3'b000) bad_cnt++;
        random_wait();
        aw_ready_o = 1'b1;
        @(negedge clk);
        aw_ready_o = 1'b0;
        while (!w_valid_i) @(negedge clk);
        random_wait();
        w_ready_o    = 1'b1;
        image[addr]  = w_data_i;
        wr_log[addr] = w_data_i;
        wb_cnt++;
        @(negedge clk);
        w_ready_o = 1'b0;
        random_wait();
        b_valid_o = 1'b1;
        while (!b_ready_i) @(negedge clk);
        @(negedge clk);
        b_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
// ####################################################################
// data cache top level
// controller, storage arrays and the link between them
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  logic              clk,
  input  logic              rst,
  // CPU side
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  dcache_pkg::addr_t ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output dcache_pkg::word_t r_data_o,
  input  logic              aw_valid_i,
  input  logic              w_valid_i,
  output logic              aw_ready_o,
  input  dcache_pkg::addr_t aw_addr_i,
  input  dcache_pkg::word_t w_data_i,
  input  dcache_pkg::strb_t w_strb_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  // memory side
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output dcache_pkg::addr_t mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  dcache_pkg::word_t mem_r_data_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output dcache_pkg::addr_t mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output dcache_pkg::word_t mem_w_data_o,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o
);

  dcache_array_if arr_if ();

  dcache_ctrl ctrl0 (
    .clk            (clk),
    .rst            (rst),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_addr_i      (ar_addr_i),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_data_o       (r_data_o),
    .aw_valid_i     (aw_valid_i),
    .w_valid_i      (w_valid_i),
    .aw_ready_o     (aw_ready_o),
    .aw_addr_i      (aw_addr_i),
    .w_data_i       (w_data_i),
    .w_strb_i       (w_strb_i),
    .b_valid_o      (b_valid_o),
    .b_ready_i      (b_ready_i),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_aw_valid_o (mem_aw_valid_o),
    .mem_aw_ready_i (mem_aw_ready_i),
    .mem_aw_addr_o  (mem_aw_addr_o),
    .mem_w_valid_o  (mem_w_valid_o),
    .mem_w_ready_i  (mem_w_ready_i),
    .mem_w_data_o   (mem_w_data_o),
    .mem_b_valid_i  (mem_b_valid_i),
    .mem_b_ready_o  (mem_b_ready_o),
    .arr            (arr_if.ctrl)
  );

  dcache_arrays arrays0 (
    .clk (clk),
    .rst (rst),
    .arr (arr_if.arrays)
  );

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl.sv
// ####################################################################
// data cache controller FSM
// CPU and memory handshakes, lookup, write merge, writeback, refill
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl (
  input  logic              clk,
  input  logic              rst,
  // CPU read
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  dcache_pkg::addr_t ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output dcache_pkg::word_t r_data_o,
  // CPU write, address and data together
  input  logic              aw_valid_i,
  input  logic              w_valid_i,
  output logic              aw_ready_o,
  input  dcache_pkg::addr_t aw_addr_i,
  input  dcache_pkg::word_t w_data_i,
  input  dcache_pkg::strb_t w_strb_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  // memory side
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output dcache_pkg::addr_t mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  dcache_pkg::word_t mem_r_data_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output dcache_pkg::addr_t mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output dcache_pkg::word_t mem_w_data_o,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o,
  dcache_array_if.ctrl      arr
);
  import dcache_pkg::*;

  dc_state_e state_q;
  dc_state_e state_d;
  logic      rd_acc;
  logic      wr_acc;
  logic      is_wr_q;    // request in flight is a write
  tag_t      tag_q;
  index_t    idx_q;
  word_t     wdata_q;
  strb_t     strb_q;
  way_t      vic_way_q;
  addr_t     wb_addr_q;
  word_t     wb_data_q;
  word_t     rdata_q;

  function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t strb);
    word_t res;
    res = old_w;
    for (int b = 0; b < `DC_DATA_W / 8; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  assign ar_ready_o = (state_q == IDLE);
  assign aw_ready_o = (state_q == IDLE) && !ar_valid_i;  // read wins
  assign rd_acc     = ar_valid_i && ar_ready_o;
  assign wr_acc     = aw_valid_i && w_valid_i && aw_ready_o;

  // lookup starts on the accepting edge
  assign arr.rd_en    = rd_acc | wr_acc;
  assign arr.rd_index = rd_acc ? ar_addr_i[`DC_OFFSET_W +: `DC_INDEX_W]
                               : aw_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
  assign arr.cmp_tag  = tag_q;
  assign arr.wr_index = idx_q;
  assign arr.wr_tag   = tag_q;
  assign arr.set_dirty = is_wr_q;

  always_comb begin
    arr.wr_en   = 1'b0;
    arr.wr_way  = arr.hit_way;
    arr.wr_data = merge_word(arr.rd_data, wdata_q, strb_q);
    if ((state_q == LOOKUP) && arr.hit && is_wr_q) begin
      arr.wr_en = 1'b1;  // write hit
    end else if ((state_q == FILL_R) && mem_r_valid_i) begin
      arr.wr_en   = 1'b1;
      arr.wr_way  = vic_way_q;
      arr.wr_data = is_wr_q ? merge_word(mem_r_data_i, wdata_q, strb_q) : mem_r_data_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (rd_acc || wr_acc) state_d = LOOKUP;
      LOOKUP: begin
        if (arr.hit) state_d = RESP;
        else if (arr.victim_valid && arr.victim_dirty) state_d = WB_AW;
        else state_d = FILL_AR;
      end
      WB_AW:   if (mem_aw_ready_i) state_d = WB_W;
      WB_W:    if (mem_w_ready_i) state_d = WB_B;
      WB_B:    if (mem_b_valid_i) state_d = FILL_AR;
      FILL_AR: if (mem_ar_ready_i) state_d = FILL_R;
      FILL_R:  if (mem_r_valid_i) state_d = RESP;
      RESP:    if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      is_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (rd_acc) is_wr_q <= 1'b0;
      else if (wr_acc) is_wr_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      tag_q <= ar_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
      idx_q <= ar_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    end else if (wr_acc) begin
      tag_q   <= aw_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
      idx_q   <= aw_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
      wdata_q <= w_data_i;
      strb_q  <= w_strb_i;
    end
    // victim is sampled once, the counter keeps moving
    if (state_q == LOOKUP) begin
      vic_way_q <= arr.victim_way;
      wb_addr_q <= {arr.victim_tag, idx_q, {`DC_OFFSET_W{1'b0}}};
      wb_data_q <= arr.victim_data;
      rdata_q   <= arr.rd_data;
    end
    if ((state_q == FILL_R) && mem_r_valid_i) rdata_q <= mem_r_data_i;
  end

  assign r_valid_o = (state_q == RESP) && !is_wr_q;
  assign b_valid_o = (state_q == RESP) && is_wr_q;
  assign r_data_o  = rdata_q;

  assign mem_aw_valid_o = (state_q == WB_AW);
  assign mem_aw_addr_o  = wb_addr_q;
  assign mem_w_valid_o  = (state_q == WB_W);
  assign mem_w_data_o   = wb_data_q;   // full word, no strobe
  assign mem_b_ready_o  = (state_q == WB_B);
  assign mem_ar_valid_o = (state_q == FILL_AR);
  assign mem_ar_addr_o  = {tag_q, idx_q, {`DC_OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == FILL_R);

endmodule

`default_nettype wire

// File: hdl/dcache_arrays.sv
// ####################################################################
// tag and data RAMs for both ways, valid and dirty bits
// hit compare and victim choice
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_arrays (
  input  logic           clk,
  input  logic           rst,
  dcache_array_if.arrays arr
);
  import dcache_pkg::*;

  tag_entry_t          tag_rd  [`DC_WAYS];
  word_t               data_rd [`DC_WAYS];
  tag_entry_t          tag_wr;
  index_t              ram_addr;
  index_t              idx_q;      // set of the last lookup
  logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
  logic [`DC_SETS-1:0] dirty_q [`DC_WAYS];
  way_t                victim_cnt_q;
  way_t                victim_way;
  way_t                hit_way;
  logic                hit_any;

  assign tag_wr.tag = arr.wr_tag;
  assign ram_addr   = arr.wr_en ? arr.wr_index : arr.rd_index;

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    logic wr_sel;

    assign wr_sel = arr.wr_en && (arr.wr_way == way_t'(w));

    dcache_sram #(.entry_t(tag_entry_t), .DEPTH(`DC_SETS)) tag_ram (
      .clk     (clk),
      .en_i    (arr.rd_en | wr_sel),
      .we_i    (wr_sel),
      .addr_i  (ram_addr),
      .wdata_i (tag_wr),
      .rdata_o (tag_rd[w])
    );

    dcache_sram #(.entry_t(word_t), .DEPTH(`DC_SETS)) data_ram (
      .clk     (clk),
      .en_i    (arr.rd_en | wr_sel),
      .we_i    (wr_sel),
      .addr_i  (ram_addr),
      .wdata_i (arr.wr_data),
      .rdata_o (data_rd[w])
    );
  end

  always_ff @(posedge clk) begin
    if (arr.rd_en) begin
      idx_q <= arr.rd_index;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      victim_cnt_q <= '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
    end else begin
      victim_cnt_q <= victim_cnt_q + 1'b1;  // free-running
      if (arr.wr_en) begin
        valid_q[arr.wr_way][arr.wr_index] <= 1'b1;
        dirty_q[arr.wr_way][arr.wr_index] <= arr.set_dirty;
      end
    end
  end

  always_comb begin
    hit_any = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (valid_q[w][idx_q] && (tag_rd[w].tag == arr.cmp_tag)) begin
        hit_any = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // lowest invalid way wins, else the counter
  always_comb begin
    victim_way = victim_cnt_q;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w][idx_q]) victim_way = way_t'(w);
    end
  end

  assign arr.hit          = hit_any;
  assign arr.hit_way      = hit_way;
  assign arr.rd_data      = data_rd[hit_way];
  assign arr.victim_way   = victim_way;
  assign arr.victim_valid = valid_q[victim_way][idx_q];
  assign arr.victim_dirty = dirty_q[victim_way][idx_q];
  assign arr.victim_tag   = tag_rd[victim_way].tag;
  assign arr.victim_data  = data_rd[victim_way];

endmodule

`default_nettype wire

// File: hdl/dcache_sram.sv
// ####################################################################
// single-port synchronous RAM, registered read
// entry type set by parameter, used for tags and data
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_sram #(
  parameter type         entry_t = dcache_pkg::word_t,
  parameter int unsigned DEPTH   = `DC_SETS
) (
  input  logic               clk,
  input  logic               en_i,
  input  logic               we_i,
  input  dcache_pkg::index_t addr_i,
  input  entry_t             wdata_i,
  output entry_t             rdata_o
);

  entry_t mem [DEPTH];

  // read output holds while idle or writing
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/dcache_array_if.sv
// ####################################################################
// controller to storage array link
// lookup, write port, hit and victim results
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if;
  import dcache_pkg::*;

  // lookup
  logic   rd_en;
  index_t rd_index;
  tag_t   cmp_tag;

  // write port
  logic   wr_en;
  way_t   wr_way;
  index_t wr_index;
  tag_t   wr_tag;
  word_t  wr_data;
  logic   set_dirty;

  // results, one cycle after rd_en
  logic   hit;
  way_t   hit_way;
  word_t  rd_data;
  way_t   victim_way;
  logic   victim_valid;
  logic   victim_dirty;
  tag_t   victim_tag;
  word_t  victim_data;

  modport ctrl (
    output rd_en, rd_index, cmp_tag,
    output wr_en, wr_way, wr_index, wr_tag, wr_data, set_dirty,
    input  hit, hit_way, rd_data,
    input  victim_way, victim_valid, victim_dirty, victim_tag, victim_data
  );

  modport arrays (
    input  rd_en, rd_index, cmp_tag,
    input  wr_en, wr_way, wr_index, wr_tag, wr_data, set_dirty,
    output hit, hit_way, rd_data,
    output victim_way, victim_valid, victim_dirty, victim_tag, victim_data
  );

endinterface

`default_nettype wire

// File: hdl/dcache_pkg.sv
// ####################################################################
// shared data cache types
// addresses, words, strobes, tag entries, controller states
// ####################################################################

`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0]     addr_t;
  typedef logic [`DC_DATA_W-1:0]     word_t;
  typedef logic [`DC_DATA_W/8-1:0]   strb_t;  // one bit per byte lane
  typedef logic [`DC_TAG_W-1:0]      tag_t;
  typedef logic [`DC_INDEX_W-1:0]    index_t;
  typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

  typedef struct packed {
    tag_t tag;
  } tag_entry_t;

  // one-hot controller states
  typedef enum logic [7:0] {
    IDLE    = 8'b0000_0001,
    LOOKUP  = 8'b0000_0010,
    WB_AW   = 8'b0000_0100,
    WB_W    = 8'b0000_1000,
    WB_B    = 8'b0001_0000,
    FILL_AR = 8'b0010_0000,
    FILL_R  = 8'b0100_0000,
    RESP    = 8'b1000_0000
  } dc_state_e;

endpackage

`default_nettype wire

// File: hdl/dcache_consts.svh
// ####################################################################
// data cache geometry and address split
// tag | index | byte offset  =  23 | 6 | 3
// ####################################################################

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`define DC_ADDR_W    32
`define DC_DATA_W    64

// address fields
`define DC_TAG_W     23
`define DC_INDEX_W   6
`define DC_OFFSET_W  3

// 64 sets x 2 ways x one word per line
`define DC_SETS      64
`define DC_WAYS      2

`endif
